/* compile.f */
+incdir+design
design/glb_pkg.sv
design/glb_port_cfg.sv
design/glb_bank_arbiter.sv
design/glb_wr_port.sv
design/glb_rd_port.sv
design/glb_bank_array.sv
design/glb_top.sv
tb/glb_props.sv
tb/glb_tb.sv

/* Makefile */
# Verilator build and run of the banked global buffer testbench.
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= glb_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) design/*.sv design/*.svh tb/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/glb_input.txt */
# wm0 wc0 wm1 wc1 rm0 rc0 rm1 rc1 stall_words stall_avail req_start0 req_stall0
# Masks and counts in decimal; stall_words 0 means reader 0 is never held
3 48 0 0 3 48 0 0 33 32 32 0
3 40 12 40 3 40 12 40 0 0 32 0
4 16 4 16 0 0 4 16 0 0 16 0

/* tb/glb_tb.sv */
// Testbench of the banked global buffer.
// Steps come from tb/glb_input.txt. Each step resets the DUT, configures all
// ports, streams LFSR data through the writers and checks every word at the
// readers against queues filled from the bank ownership rules.

`include "glb_cfg.svh"
`timescale 1ns/1ps

module glb_tb import glb_pkg::*; ();

    localparam int MAX_STEPS = 8;
    localparam int NCOL      = 12;
    localparam int C_STALL   = 8;
    localparam int C_AVAIL   = 9;
    localparam int C_REQ0    = 10;
    localparam int C_REQFULL = 11;

    logic                     clk;
    logic                     rst_n;
    logic [`GLB_NUM_PORT-1:0] cfg_vld;
    glb_port_cfg_t            cfg        [`GLB_NUM_PORT];
    logic [`GLB_NUM_PORT-1:0] cfg_rdy;
    logic [`GLB_NUM_WR-1:0]   wr_vld;
    glb_data_t                wr_dat     [`GLB_NUM_WR];
    logic [`GLB_NUM_WR-1:0]   wr_rdy;
    glb_addr_t                wr_req_num [`GLB_NUM_WR];
    logic [`GLB_NUM_RD-1:0]   rd_rdy;
    logic [`GLB_NUM_RD-1:0]   rd_vld;
    glb_data_t                rd_dat     [`GLB_NUM_RD];
    glb_addr_t                rd_avail   [`GLB_NUM_RD];

    int        tab [MAX_STEPS][NCOL];
    int        nsteps;
    int        limit;
    int        cycles;
    int        data_errs;
    int        addr_errs;
    int        flag_errs;
    int        other_errs;
    logic [15:0] lfsr;
    glb_data_t exp_q [`GLB_NUM_RD][$];

    glb_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld_i    (cfg_vld),
        .cfg_i        (cfg),
        .cfg_rdy_o    (cfg_rdy),
        .wr_vld_i     (wr_vld),
        .wr_dat_i     (wr_dat),
        .wr_rdy_o     (wr_rdy),
        .wr_req_num_o (wr_req_num),
        .rd_rdy_i     (rd_rdy),
        .rd_vld_o     (rd_vld),
        .rd_dat_o     (rd_dat),
        .rd_avail_o   (rd_avail)
    );

    always #50 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: run exceeded %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ========================================
    // Random source
    // ========================================
    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 16'hB400;
        return b;
    endfunction

    function automatic glb_data_t lfsr_word();
        glb_data_t d;
        for (int i = 0; i < `GLB_DATA_W; i++) begin
            d[i] = lfsr_bit();
        end
        return d;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_data(string name, glb_data_t got, glb_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, glb_addr_t got, glb_addr_t exp);
        if (got !== exp) begin
            addr_errs++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Reader that receives word a of writer w, or -1 when the write is dropped
    function automatic int route(int s, int w, int a);
        int mask;
        int nb;
        int first;
        int bank;
        mask  = tab[s][2 * w];
        nb    = 0;
        first = -1;
        if (mask == 0) return -1;
        for (int b = 0; b < `GLB_NUM_BANK; b++) begin
            if ((mask >> b) & 1) begin
                nb++;
                if (first < 0) first = b;
            end
        end
        bank = first + (a % (nb * `GLB_BANK_DEPTH)) / `GLB_BANK_DEPTH;
        for (int v = 0; v < `GLB_NUM_WR; v++) begin
            if ((tab[s][2 * v] >> bank) & 1) begin
                if (v != w) return -1;
                break;
            end
        end
        for (int r = 0; r < `GLB_NUM_RD; r++) begin
            if ((tab[s][4 + 2 * r] >> bank) & 1) return r;
        end
        return -1;
    endfunction

    task automatic read_steps();
        int    fd;
        int    n;
        string line;
        fd     = $fopen("tb/glb_input.txt", "r");
        nsteps = 0;
        if (fd == 0) begin
            other_errs++;
            $display("could not open the stimulus file");
        end else begin
            while (!$feof(fd) && nsteps < MAX_STEPS) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                        tab[nsteps][0], tab[nsteps][1], tab[nsteps][2], tab[nsteps][3],
                        tab[nsteps][4], tab[nsteps][5], tab[nsteps][6], tab[nsteps][7],
                        tab[nsteps][8], tab[nsteps][9], tab[nsteps][10], tab[nsteps][11]);
                    if (n == NCOL) nsteps++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_step(int s);
        int        wcnt [`GLB_NUM_WR];
        glb_data_t nxt  [`GLB_NUM_WR];
        logic      stalled;
        logic      done;
        int        dest;

        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        for (int p = 0; p < `GLB_NUM_PORT; p++) check_flag("cfg_rdy_o", cfg_rdy[p], 1'b1);
        for (int w = 0; w < `GLB_NUM_WR; w++) check_flag("wr_rdy_o", wr_rdy[w], 1'b0);
        for (int r = 0; r < `GLB_NUM_RD; r++) check_flag("rd_vld_o", rd_vld[r], 1'b0);

        // Configure every port with one strobe
        @(posedge clk);
        cfg_vld <= '1;
        for (int p = 0; p < `GLB_NUM_PORT; p++) begin
            cfg[p] <= '{mask:  glb_bank_mask_t'(tab[s][2 * p]),
                        count: glb_addr_t'(tab[s][2 * p + 1])};
        end
        @(posedge clk);
        cfg_vld <= '0;
        @(negedge clk);
        for (int p = 0; p < `GLB_NUM_PORT; p++) check_flag("cfg_rdy_o", cfg_rdy[p], 1'b0);
        @(negedge clk);
        check_addr("wr_req_num_o[0]", wr_req_num[0], glb_addr_t'(tab[s][C_REQ0]));

        for (int w = 0; w < `GLB_NUM_WR; w++) begin
            wcnt[w] = 0;
            nxt[w]  = lfsr_word();
        end
        stalled = (tab[s][C_STALL] != 0);
        done    = 1'b0;

        while (!done) begin
            for (int w = 0; w < `GLB_NUM_WR; w++) begin
                if (wr_vld[w] && wr_rdy[w]) begin
                    dest = route(s, w, wcnt[w]);
                    if (dest >= 0) exp_q[dest].push_back(wr_dat[w]);
                    wcnt[w]++;
                    nxt[w] = lfsr_word();
                end
            end
            // Writer 0 has filled the ring behind the held reader
            if (stalled && wr_vld[0] && !wr_rdy[0]) begin
                check_addr("words written", glb_addr_t'(wcnt[0]), glb_addr_t'(tab[s][C_STALL]));
                check_addr("rd_avail_o[0]", rd_avail[0], glb_addr_t'(tab[s][C_AVAIL]));
                check_addr("wr_req_num_o[0]", wr_req_num[0], glb_addr_t'(tab[s][C_REQFULL]));
                stalled = 1'b0;
            end
            for (int r = 0; r < `GLB_NUM_RD; r++) begin
                if (rd_vld[r] && rd_rdy[r]) begin
                    if (exp_q[r].size() == 0) begin
                        other_errs++;
                        $display("read port %0d returned a word that was never written", r);
                    end else begin
                        check_data($sformatf("rd_dat_o[%0d]", r), rd_dat[r],
                                   exp_q[r].pop_front());
                    end
                end
            end

            done = 1'b1;
            for (int w = 0; w < `GLB_NUM_WR; w++) begin
                if (wcnt[w] < tab[s][2 * w + 1]) done = 1'b0;
            end
            for (int r = 0; r < `GLB_NUM_RD; r++) begin
                if (exp_q[r].size() != 0 || rd_vld[r]) done = 1'b0;
            end

            @(posedge clk);
            for (int w = 0; w < `GLB_NUM_WR; w++) begin
                wr_vld[w] <= (wcnt[w] < tab[s][2 * w + 1]);
                wr_dat[w] <= nxt[w];
            end
            for (int r = 0; r < `GLB_NUM_RD; r++) begin
                rd_rdy[r] <= (stalled && r == 0) ? 1'b0 : lfsr_bit();
            end
            @(negedge clk);
        end

        // Every writer has sent its whole count
        for (int w = 0; w < `GLB_NUM_WR; w++) begin
            check_flag("wr_rdy_o", wr_rdy[w], 1'b0);
            check_addr($sformatf("wr_req_num_o[%0d]", w), wr_req_num[w], '0);
        end
        for (int r = 0; r < `GLB_NUM_RD; r++) begin
            check_addr($sformatf("rd_avail_o[%0d]", r), rd_avail[r], '0);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        cfg_vld    = '0;
        wr_vld     = '0;
        rd_rdy     = '0;
        for (int p = 0; p < `GLB_NUM_PORT; p++) cfg[p] = '0;
        for (int w = 0; w < `GLB_NUM_WR; w++) wr_dat[w] = '0;
        lfsr       = 16'd84;
        cycles     = 0;
        limit      = 0;
        data_errs  = 0;
        addr_errs  = 0;
        flag_errs  = 0;
        other_errs = 0;

        read_steps();
        // Four cycles per word plus room for reset and configuration
        for (int s = 0; s < nsteps; s++) begin
            limit += 4 * (tab[s][1] + tab[s][3]) + 100;
        end
        limit += 200;

        for (int s = 0; s < nsteps; s++) begin
            run_step(s);
        end
        if (nsteps == 0) begin
            other_errs++;
            $display("no test steps found in the stimulus file");
        end

        $display("errors: data %0d, count %0d, flag %0d, other %0d",
                 data_errs, addr_errs, flag_errs, other_errs);
        if (data_errs + addr_errs + flag_errs + other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb/glb_props.sv */
// Protocol rules of the buffer top level, checked by concurrent assertions.
// Bound into every glb_top instance.

`include "glb_cfg.svh"
`timescale 1ns/1ps

module glb_props import glb_pkg::*; (
    input logic                     clk,
    input logic                     rst_n,
    input logic [`GLB_NUM_PORT-1:0] cfg_rdy_i,
    input logic [`GLB_NUM_WR-1:0]   wr_rdy_i,
    input logic [`GLB_NUM_RD-1:0]   rd_vld_i,
    input logic [`GLB_NUM_RD-1:0]   rd_rdy_i,
    input glb_data_t                rd_dat_i   [`GLB_NUM_RD],
    input glb_addr_t                rd_avail_i [`GLB_NUM_RD],
    input glb_port_geom_t           geom_i     [`GLB_NUM_PORT]
);

    for (genvar p = 0; p < `GLB_NUM_PORT; p++) begin : g_cfg
        // Ready is one-shot until the next reset
        a_cfg_once: assert property (@(posedge clk) disable iff (!rst_n)
            !cfg_rdy_i[p] |=> !cfg_rdy_i[p]) else $error("cfg ready rose again on port %0d", p);
    end

    for (genvar w = 0; w < `GLB_NUM_WR; w++) begin : g_wr
        a_wr_unalloc: assert property (@(posedge clk) disable iff (!rst_n)
            !geom_i[w].alloc |-> !wr_rdy_i[w]) else $error("write port %0d ready unallocated", w);
    end

    for (genvar r = 0; r < `GLB_NUM_RD; r++) begin : g_rd
        a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
            rd_vld_i[r] && !rd_rdy_i[r] |=> $stable(rd_dat_i[r]))
            else $error("read data changed under back-pressure on port %0d", r);
        a_rd_avail: assert property (@(posedge clk) disable iff (!rst_n)
            rd_avail_i[r] <= geom_i[`GLB_NUM_WR + r].range)
            else $error("read port %0d reports more words than its ring holds", r);
    end

endmodule

bind glb_top glb_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_rdy_i  (cfg_rdy_o),
    .wr_rdy_i   (wr_rdy_o),
    .rd_vld_i   (rd_vld_o),
    .rd_rdy_i   (rd_rdy_i),
    .rd_dat_i   (rd_dat_o),
    .rd_avail_i (rd_avail_o),
    .geom_i     (geom)
);

/* design/glb_top.sv */
// Top level of the banked global buffer.
// Ties the configuration registers, the bank arbiter, the write and read
// ports and the bank memories together. Each port finds its partner through
// the owner, on the other side, of the bank its current address maps to.
// Port configuration index runs over write ports first, then read ports.

`include "glb_cfg.svh"
`timescale 1ns/1ps

module glb_top import glb_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`GLB_NUM_PORT-1:0] cfg_vld_i,
    input  glb_port_cfg_t            cfg_i        [`GLB_NUM_PORT],
    output logic [`GLB_NUM_PORT-1:0] cfg_rdy_o,
    input  logic [`GLB_NUM_WR-1:0]   wr_vld_i,
    input  glb_data_t                wr_dat_i     [`GLB_NUM_WR],
    output logic [`GLB_NUM_WR-1:0]   wr_rdy_o,
    output glb_addr_t                wr_req_num_o [`GLB_NUM_WR],
    input  logic [`GLB_NUM_RD-1:0]   rd_rdy_i,
    output logic [`GLB_NUM_RD-1:0]   rd_vld_o,
    output glb_data_t                rd_dat_o     [`GLB_NUM_RD],
    output glb_addr_t                rd_avail_o   [`GLB_NUM_RD]
);

    logic [`GLB_NUM_PORT-1:0] cfg_clr;
    glb_bank_mask_t           mask       [`GLB_NUM_PORT];
    glb_addr_t                count      [`GLB_NUM_PORT];
    glb_port_geom_t           geom       [`GLB_NUM_PORT];
    glb_wr_idx_t              wr_owner   [`GLB_NUM_BANK];
    glb_rd_idx_t              rd_owner   [`GLB_NUM_BANK];
    glb_addr_t                wr_addr    [`GLB_NUM_WR];
    glb_bank_idx_t            wr_bank    [`GLB_NUM_WR];
    glb_addr_t                partner_rd [`GLB_NUM_WR];
    glb_bank_wr_t             bank_wr    [`GLB_NUM_WR];
    glb_addr_t                rd_addr    [`GLB_NUM_RD];
    glb_bank_idx_t            rd_bank    [`GLB_NUM_RD];
    glb_addr_t                partner_wr [`GLB_NUM_RD];
    glb_bank_rd_t             bank_rd    [`GLB_NUM_RD];
    glb_data_t                rdata      [`GLB_NUM_RD];

    glb_port_cfg u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_vld_i (cfg_vld_i),
        .cfg_i     (cfg_i),
        .cfg_rdy_o (cfg_rdy_o),
        .cfg_clr_o (cfg_clr),
        .mask_o    (mask),
        .count_o   (count),
        .geom_o    (geom)
    );

    glb_bank_arbiter u_arb (
        .mask_i     (mask),
        .wr_owner_o (wr_owner),
        .rd_owner_o (rd_owner)
    );

    // ========================================
    // Write ports
    // ========================================
    for (genvar w = 0; w < `GLB_NUM_WR; w++) begin : g_wr
        // Reader owning the bank under this write address
        assign partner_rd[w] = rd_addr[rd_owner[wr_bank[w]]];

        glb_wr_port u_wr (
            .clk               (clk),
            .rst_n             (rst_n),
            .clr_i             (cfg_clr[w]),
            .geom_i            (geom[w]),
            .count_i           (count[w]),
            .wr_vld_i          (wr_vld_i[w]),
            .wr_dat_i          (wr_dat_i[w]),
            .partner_rd_addr_i (partner_rd[w]),
            .addr_o            (wr_addr[w]),
            .bank_o            (wr_bank[w]),
            .wr_rdy_o          (wr_rdy_o[w]),
            .wr_req_num_o      (wr_req_num_o[w]),
            .bank_wr_o         (bank_wr[w])
        );
    end

    // ========================================
    // Read ports
    // ========================================
    for (genvar r = 0; r < `GLB_NUM_RD; r++) begin : g_rd
        assign partner_wr[r] = wr_addr[wr_owner[rd_bank[r]]];

        glb_rd_port u_rd (
            .clk               (clk),
            .rst_n             (rst_n),
            .clr_i             (cfg_clr[`GLB_NUM_WR + r]),
            .geom_i            (geom[`GLB_NUM_WR + r]),
            .count_i           (count[`GLB_NUM_WR + r]),
            .partner_wr_addr_i (partner_wr[r]),
            .bank_rdata_i      (rdata[r]),
            .addr_o            (rd_addr[r]),
            .bank_o            (rd_bank[r]),
            .rd_rdy_i          (rd_rdy_i[r]),
            .rd_vld_o          (rd_vld_o[r]),
            .rd_dat_o          (rd_dat_o[r]),
            .rd_avail_o        (rd_avail_o[r]),
            .bank_rd_o         (bank_rd[r])
        );
    end

    glb_bank_array u_banks (
        .clk        (clk),
        .bank_wr_i  (bank_wr),
        .bank_rd_i  (bank_rd),
        .wr_owner_i (wr_owner),
        .rd_owner_i (rd_owner),
        .rdata_o    (rdata)
    );

endmodule

/* design/glb_bank_array.sv */
// Memory banks of the buffer, simple dual-port.
// Each bank accepts a write only from its owning write port and a read only
// from its owning read port. Read data is registered per read port and stays
// until that port launches its next read.

`include "glb_cfg.svh"
`timescale 1ns/1ps

module glb_bank_array import glb_pkg::*; (
    input  logic         clk,
    input  glb_bank_wr_t bank_wr_i  [`GLB_NUM_WR],
    input  glb_bank_rd_t bank_rd_i  [`GLB_NUM_RD],
    input  glb_wr_idx_t  wr_owner_i [`GLB_NUM_BANK],
    input  glb_rd_idx_t  rd_owner_i [`GLB_NUM_BANK],
    output glb_data_t    rdata_o    [`GLB_NUM_RD]
);

    glb_data_t                mem    [`GLB_NUM_BANK][`GLB_BANK_DEPTH];
    glb_bank_wr_t             wr_sel [`GLB_NUM_BANK];
    logic [`GLB_NUM_BANK-1:0] wr_hit;
    logic [`GLB_NUM_RD-1:0]   rd_hit;

    // Write steering from the owner of each bank
    for (genvar b = 0; b < `GLB_NUM_BANK; b++) begin : g_wr
        assign wr_sel[b] = bank_wr_i[wr_owner_i[b]];
        assign wr_hit[b] = wr_sel[b].en && (wr_sel[b].bank == glb_bank_idx_t'(b));
    end

    // Read accepted only when the port owns the target bank
    for (genvar r = 0; r < `GLB_NUM_RD; r++) begin : g_rd
        assign rd_hit[r] = bank_rd_i[r].en
                         && (rd_owner_i[bank_rd_i[r].bank] == glb_rd_idx_t'(r));
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < `GLB_NUM_BANK; b++) begin
            if (wr_hit[b]) begin
                mem[b][wr_sel[b].word] <= wr_sel[b].data;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < `GLB_NUM_RD; r++) begin
            if (rd_hit[r]) begin
                rdata_o[r] <= mem[bank_rd_i[r].bank][bank_rd_i[r].word];
            end
        end
    end

endmodule

/* design/glb_rd_port.sv */
// One read port of the buffer.
// The port reads words in address order once its matched writer has passed
// them. A bank read is launched when the output stage is free or being taken;
// data returns one cycle later in the bank read register, which holds it
// under back-pressure. One word is in flight at a time.

`include "glb_cfg.svh"
`timescale 1ns/1ps

module glb_rd_port import glb_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clr_i,
    input  glb_port_geom_t geom_i,
    input  glb_addr_t      count_i,
    input  glb_addr_t      partner_wr_addr_i,
    input  glb_data_t      bank_rdata_i,
    output glb_addr_t      addr_o,
    output glb_bank_idx_t  bank_o,
    input  logic           rd_rdy_i,
    output logic           rd_vld_o,
    output glb_data_t      rd_dat_o,
    output glb_addr_t      rd_avail_o,
    output glb_bank_rd_t   bank_rd_o
);

    glb_addr_t addr_q;
    glb_addr_t off;
    logic      launch;
    logic      vld_q;

    // ========================================
    // Address to bank and word
    // ========================================
    assign off    = (geom_i.range == '0) ? '0 : addr_q % geom_i.range;
    assign bank_o = geom_i.first + glb_bank_idx_t'(off >> $bits(glb_word_t));
    assign addr_o = addr_q;

    // Not empty and output stage free
    assign launch = geom_i.alloc && !clr_i && (addr_q < count_i)
                  && (addr_q < partner_wr_addr_i) && (!vld_q || rd_rdy_i);

    assign bank_rd_o.en   = launch;
    assign bank_rd_o.bank = bank_o;
    assign bank_rd_o.word = glb_word_t'(addr_q);

    assign rd_avail_o = geom_i.alloc ? partner_wr_addr_i - addr_q : '0;

    // Counter and output valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
            vld_q  <= 1'b0;
        end else if (clr_i) begin
            addr_q <= '0;
            vld_q  <= 1'b0;
        end else begin
            if (launch) begin
                addr_q <= addr_q + glb_addr_t'(1);
                vld_q  <= 1'b1;
            end else if (rd_rdy_i) begin
                vld_q  <= 1'b0;
            end
        end
    end

    // Bank read register keeps the word until the next launch
    assign rd_dat_o = bank_rdata_i;
    assign rd_vld_o = vld_q;

endmodule

/* design/glb_wr_port.sv */
// One write port of the buffer.
// Words stream in by valid/ready and land at consecutive addresses. The
// address wraps around the ring of allocated banks; the port stalls when the
// matched reader is a full ring behind. The request count tells the producer
// how many words it may still send.

`include "glb_cfg.svh"
`timescale 1ns/1ps

module glb_wr_port import glb_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clr_i,
    input  glb_port_geom_t geom_i,
    input  glb_addr_t      count_i,
    input  logic           wr_vld_i,
    input  glb_data_t      wr_dat_i,
    input  glb_addr_t      partner_rd_addr_i,
    output glb_addr_t      addr_o,
    output glb_bank_idx_t  bank_o,
    output logic           wr_rdy_o,
    output glb_addr_t      wr_req_num_o,
    output glb_bank_wr_t   bank_wr_o
);

    glb_addr_t addr_q;
    glb_addr_t off;
    glb_addr_t used;
    glb_addr_t remain;
    glb_addr_t space;
    logic      xfer;

    // ========================================
    // Address to bank and word
    // ========================================
    assign off    = (geom_i.range == '0) ? '0 : addr_q % geom_i.range;
    assign bank_o = geom_i.first + glb_bank_idx_t'(off >> $bits(glb_word_t));
    assign addr_o = addr_q;

    // Words written but not yet read
    assign used   = addr_q - partner_rd_addr_i;

    assign wr_rdy_o = geom_i.alloc && !clr_i && (addr_q < count_i)
                    && (used < geom_i.range);
    assign xfer     = wr_vld_i && wr_rdy_o;

    // Smaller of remaining words and free ring space
    assign remain = count_i - addr_q;
    assign space  = (used < geom_i.range) ? geom_i.range - used : '0;
    assign wr_req_num_o = !geom_i.alloc   ? '0 :
                          (remain < space) ? remain : space;

    assign bank_wr_o.en   = xfer;
    assign bank_wr_o.bank = bank_o;
    assign bank_wr_o.word = glb_word_t'(addr_q);
    assign bank_wr_o.data = wr_dat_i;

    // Address counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (clr_i) begin
            addr_q <= '0;
        end else if (xfer) begin
            addr_q <= addr_q + glb_addr_t'(1);
        end
    end

endmodule

/* design/glb_bank_arbiter.sv */
// Bank ownership from the latched port masks.
// For every bank the lowest-indexed write port and the lowest-indexed read
// port whose mask has that bank become its owners. A bank that no port asks
// for defaults to port 0 on both sides.

`include "glb_cfg.svh"
`timescale 1ns/1ps

module glb_bank_arbiter import glb_pkg::*; (
    input  glb_bank_mask_t mask_i     [`GLB_NUM_PORT],
    output glb_wr_idx_t    wr_owner_o [`GLB_NUM_BANK],
    output glb_rd_idx_t    rd_owner_o [`GLB_NUM_BANK]
);

    for (genvar b = 0; b < `GLB_NUM_BANK; b++) begin : g_bank

        // Write side, scan from the top so the lowest index wins
        always_comb begin
            wr_owner_o[b] = '0;
            for (int w = `GLB_NUM_WR - 1; w >= 0; w--) begin
                if (mask_i[w][b]) begin
                    wr_owner_o[b] = glb_wr_idx_t'(w);
                end
            end
        end

        // Read side, masks sit after the write ports
        always_comb begin
            rd_owner_o[b] = '0;
            for (int r = `GLB_NUM_RD - 1; r >= 0; r--) begin
                if (mask_i[`GLB_NUM_WR + r][b]) begin
                    rd_owner_o[b] = glb_rd_idx_t'(r);
                end
            end
        end

    end

endmodule

/* design/glb_port_cfg.sv */
// Configuration registers of all buffer ports.
// Write ports come first in the port index, then read ports. Each port takes
// one strobe; the values are latched and the geometry follows from them.
// A one-cycle clear pulse restarts the port's address counter.

`include "glb_cfg.svh"
`timescale 1ns/1ps

module glb_port_cfg import glb_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`GLB_NUM_PORT-1:0]  cfg_vld_i,
    input  glb_port_cfg_t             cfg_i   [`GLB_NUM_PORT],
    output logic [`GLB_NUM_PORT-1:0]  cfg_rdy_o,
    output logic [`GLB_NUM_PORT-1:0]  cfg_clr_o,
    output glb_bank_mask_t            mask_o  [`GLB_NUM_PORT],
    output glb_addr_t                 count_o [`GLB_NUM_PORT],
    output glb_port_geom_t            geom_o  [`GLB_NUM_PORT]
);

    localparam int CNT_W = $clog2(`GLB_NUM_BANK) + 1;

    glb_port_cfg_t cfg_q [`GLB_NUM_PORT];

    // Latch on strobe, ready flag falls once and stays low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_rdy_o <= '1;
            cfg_clr_o <= '0;
            for (int p = 0; p < `GLB_NUM_PORT; p++) begin
                cfg_q[p] <= '0;
            end
        end else begin
            cfg_clr_o <= cfg_vld_i;
            for (int p = 0; p < `GLB_NUM_PORT; p++) begin
                if (cfg_vld_i[p]) begin
                    cfg_q[p]     <= cfg_i[p];
                    cfg_rdy_o[p] <= 1'b0;
                end
            end
        end
    end

    for (genvar p = 0; p < `GLB_NUM_PORT; p++) begin : g_port
        glb_bank_idx_t    first;
        logic [CNT_W-1:0] nbank;

        // Lowest set mask bit and number of banks
        always_comb begin
            first = '0;
            nbank = '0;
            for (int b = `GLB_NUM_BANK - 1; b >= 0; b--) begin
                if (cfg_q[p].mask[b]) begin
                    first = glb_bank_idx_t'(b);
                    nbank = nbank + CNT_W'(1);
                end
            end
        end

        assign mask_o[p]        = cfg_q[p].mask;
        assign count_o[p]       = cfg_q[p].count;
        assign geom_o[p].alloc  = |cfg_q[p].mask;
        assign geom_o[p].first  = first;
        assign geom_o[p].range  = glb_addr_t'(nbank) * glb_addr_t'(`GLB_BANK_DEPTH);
    end

endmodule

/* design/glb_pkg.sv */
// Shared types for the banked global buffer.
// The RTL and the testbench import this package. Widths follow the macros in
// the configuration header.

`include "glb_cfg.svh"

package glb_pkg;

    // ========================================
    // Vector types
    // ========================================
    typedef logic [`GLB_DATA_W-1:0]             glb_data_t;
    typedef logic [`GLB_ADDR_W-1:0]             glb_addr_t;
    typedef logic [$clog2(`GLB_BANK_DEPTH)-1:0] glb_word_t;
    typedef logic [$clog2(`GLB_NUM_BANK)-1:0]   glb_bank_idx_t;
    typedef logic [`GLB_NUM_BANK-1:0]           glb_bank_mask_t;
    typedef logic [$clog2(`GLB_NUM_WR)-1:0]     glb_wr_idx_t;
    typedef logic [$clog2(`GLB_NUM_RD)-1:0]     glb_rd_idx_t;

    // ========================================
    // Bundles
    // ========================================
    // Carried by one configuration strobe
    typedef struct packed {
        glb_bank_mask_t mask;
        glb_addr_t      count;
    } glb_port_cfg_t;

    // Derived from the latched configuration
    typedef struct packed {
        logic          alloc;
        glb_bank_idx_t first;
        glb_addr_t     range;
    } glb_port_geom_t;

    // Bank write request from a write port
    typedef struct packed {
        logic          en;
        glb_bank_idx_t bank;
        glb_word_t     word;
        glb_data_t     data;
    } glb_bank_wr_t;

    // Bank read request from a read port
    typedef struct packed {
        logic          en;
        glb_bank_idx_t bank;
        glb_word_t     word;
    } glb_bank_rd_t;

endpackage

/* design/glb_cfg.svh */
// Size settings for the banked global buffer.
// Include this in every package or module that needs port, bank or width counts.
// Bank depth must stay a power of two, since the word index is taken from the
// low address bits.

`ifndef GLB_CFG_SVH
`define GLB_CFG_SVH

// Port counts
`define GLB_NUM_WR      2
`define GLB_NUM_RD      2
`define GLB_NUM_PORT    (`GLB_NUM_WR + `GLB_NUM_RD)

// Bank geometry
`define GLB_NUM_BANK    4
`define GLB_BANK_DEPTH  16

// Data and address widths
`define GLB_DATA_W      16
`define GLB_ADDR_W      8

`endif
